//--- Bender.yml
package:
  name: vread

sources:
  - src/vread_cfg_pkg.sv
  - src/vread_bus_pkg.sv
  - src/vread_addr_gen.sv
  - src/vread_fetch.sv
  - src/vread_buffer.sv
  - src/vread_emit.sv
  - src/vread_top.sv
  - target: test
    files:
      - bench/vread_mem_model.sv
      - bench/tb_vread.sv

//--- bench/tb_vread.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vread import vread_cfg_pkg::*, vread_bus_pkg::*; ();

   logic                  clk;
   logic                  rst;
   logic                  run;
   logic                  pingpong;
   read_cfg_t             read_cfg;
   out_cfg_t              out_cfg;
   logic [7:0]            delay;
   db_req_t               db_req;
   db_rsp_t               db_rsp;
   logic [7:0]            data;
   logic                  data_valid;
   logic                  done;
   logic [31:0]           beats;
   logic                  burst_done;

   logic [31:0]           shadow [1024];
   logic [GEN_ADDR_W-1:0] walk_q [$];
   logic [7:0]            exp_q [$];
   logic                  bank_ref;
   logic                  fetch_on;
   logic [31:0]           beats_exp;
   int                    checked;
   string                 test_name;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   vread_top #(
      .DATA_W (8),
      .DELAY_W(8)
   ) vread_top_i (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run),
      .pingpong_i  (pingpong),
      .read_cfg_i  (read_cfg),
      .out_cfg_i   (out_cfg),
      .delay_i     (delay),
      .db_req_o    (db_req),
      .db_rsp_i    (db_rsp),
      .data_o      (data),
      .data_valid_o(data_valid),
      .done_o      (done)
   );

   vread_mem_model mem_i (
      .clk         (clk),
      .rst         (rst),
      .req_i       (db_req),
      .rsp_o       (db_rsp),
      .beats_o     (beats),
      .burst_done_o(burst_done)
   );

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input logic [31:0] exp, input logic [31:0] act);
      stop_with_failure($sformatf("[ERROR] %s: expected %0h, actual %0h",
                                  test_name, exp, act));
   endtask

   function automatic gen_cfg_t make_gen(input int start, input int per, input int duty,
                                         input int incr, input int iter, input int shift,
                                         input int iter2, input int shift2);
      gen_cfg_t g;
      g.start  = GEN_ADDR_W'(start);
      g.per    = PER_W'(per);
      g.duty   = PER_W'(duty);
      g.incr   = GEN_ADDR_W'(incr);
      g.iter   = GEN_ADDR_W'(iter);
      g.shift  = GEN_ADDR_W'(shift);
      g.iter2  = GEN_ADDR_W'(iter2);
      g.shift2 = GEN_ADDR_W'(shift2);
      return g;
   endfunction

   function automatic read_cfg_t make_read(input logic en, input logic [31:0] addr,
                                           input int len, input gen_cfg_t g);
      read_cfg_t rc;
      rc.enabled  = en;
      rc.ext_addr = addr;
      rc.length   = LEN_W'(len);
      rc.gen      = g;
      return rc;
   endfunction

   // all valid addresses of one generator run where a zero count acts as one
   task automatic expand_walk(input gen_cfg_t g);
      logic [GEN_ADDR_W-1:0] a;
      int                    n_per;
      int                    n_iter;
      int                    n_loop;
      a      = g.start;
      n_per  = (g.per == '0) ? 1 : int'(g.per);
      n_iter = (g.iter == '0) ? 1 : int'(g.iter);
      n_loop = (g.iter2 == '0) ? 1 : int'(g.iter2);
      walk_q.delete();
      for (int l = 0; l < n_loop; l++) begin
         for (int p = 0; p < n_iter; p++) begin
            for (int s = 0; s < n_per; s++) begin
               if (s < int'(g.duty)) begin
                  walk_q.push_back(a);
               end
               if (s != n_per - 1) begin
                  a = a + g.incr;
               end else if (p != n_iter - 1) begin
                  a = a + g.shift;
               end else begin
                  a = a + g.shift2;
               end
            end
         end
      end
   endtask

   task automatic next_cycle();
      logic [7:0] exp;
      @(negedge clk);
      if (data_valid) begin
         if (exp_q.size() == 0) begin
            stop_with_failure($sformatf("output word beyond the expected ones in %s",
                                        test_name));
         end else begin
            exp = exp_q.pop_front();
            assert (data == exp) else report_mismatch(32'(exp), 32'(data));
            checked++;
         end
      end
      if (!fetch_on) begin
         assert (!db_req.valid) else stop_with_failure("databus request with fetch disabled");
      end
   endtask

   task automatic start_run(input string name, input logic pp, input read_cfg_t rc,
                            input gen_cfg_t emit_gen, input logic [7:0] dly);
      gen_cfg_t              g;
      logic [BUF_ADDR_W-1:0] w;
      logic [GEN_ADDR_W-1:0] a;
      test_name    = name;
      run          = 1'b1;
      pingpong     = pp;
      read_cfg     = rc;
      out_cfg.gen  = emit_gen;
      delay        = dly;
      bank_ref     = pp ? !bank_ref : 1'b0;
      expand_walk(emit_gen);
      foreach (walk_q[i]) begin
         a = walk_q[i];
         w = a[BUF_ADDR_W+1:2];
         if (pp) begin
            w[BUF_ADDR_W-1] = bank_ref;
         end
         exp_q.push_back(shadow[w][{a[1:0], 3'b000} +: 8]);
      end
      fetch_on = rc.enabled;
      if (rc.enabled) begin
         g        = rc.gen;
         g.start  = '0;
         g.iter2  = GEN_ADDR_W'(1);
         g.shift2 = '0;
         expand_walk(g);
         if (walk_q.size() <= int'(rc.length)) begin
            stop_with_failure("fetch generator yields fewer addresses than beats");
         end else begin
            for (int k = 0; k <= int'(rc.length); k++) begin
               w = walk_q[k][BUF_ADDR_W-1:0];
               if (pp) begin
                  w[BUF_ADDR_W-1] = !bank_ref;
               end
               shadow[w] = (rc.ext_addr + 32'(k) * 4) ^ 32'h5a5a_0000;
            end
            beats_exp = beats_exp + 32'(rc.length) + 32'd1;
         end
      end
      next_cycle();
      run = 1'b0;
      assert (!done) else report_mismatch(32'd0, 32'(done));
   endtask

   // done must wait for the last beat and the last output word
   task automatic wait_done();
      int cycles;
      cycles = 0;
      while (!done && cycles < 4000) begin
         next_cycle();
         cycles++;
      end
      if (!done) begin
         stop_with_failure($sformatf("timeout waiting for done_o in %s", test_name));
      end else begin
         assert (exp_q.size() == 0) else report_mismatch(32'd0, 32'(exp_q.size()));
         assert (beats == beats_exp) else report_mismatch(beats_exp, beats);
         assert (burst_done) else stop_with_failure("burst did not end on last");
         assert (!db_req.valid) else stop_with_failure("request still valid after done");
      end
   endtask

   initial begin
      gen_cfg_t  idle_emit;
      gen_cfg_t  lane_walk;
      gen_cfg_t  word_walk;
      read_cfg_t no_read;
      rst       = 1'b1;
      run       = 1'b0;
      pingpong  = 1'b0;
      read_cfg  = '0;
      out_cfg   = '0;
      delay     = '0;
      bank_ref  = 1'b0;
      fetch_on  = 1'b0;
      beats_exp = '0;
      checked   = 0;
      test_name = "reset";
      idle_emit = make_gen(0, 1, 0, 0, 1, 0, 1, 0);
      lane_walk = make_gen(0, 64, 64, 1, 1, 0, 1, 0);
      word_walk = make_gen(0, 1, 1, 0, 16, 1, 1, 0);
      no_read   = make_read(1'b0, 32'h0, 0, word_walk);
      repeat (3) @(negedge clk);
      rst = 1'b0;
      next_cycle();
      assert (done && !db_req.valid && !data_valid)
         else stop_with_failure("outputs not idle after reset");

      start_run("linear_load", 1'b0, make_read(1'b1, 32'h0000_1000, 15, word_walk),
                idle_emit, 8'd0);
      wait_done();
      start_run("linear_emit", 1'b0, no_read, lane_walk, 8'd2);
      wait_done();
      start_run("strided_emit", 1'b0, no_read, make_gen(1, 4, 3, 2, 3, 3, 2, 13), 8'd0);
      wait_done();
      // one idle step per word holds the bus back
      start_run("gapped_load", 1'b0,
                make_read(1'b1, 32'h0002_0040, 7, make_gen(0, 2, 1, 1, 8, 1, 1, 0)),
                idle_emit, 8'd0);
      wait_done();
      start_run("gapped_emit", 1'b0, no_read, lane_walk, 8'd5);
      wait_done();
      start_run("pingpong_1", 1'b1, make_read(1'b1, 32'h0003_0000, 15, word_walk),
                idle_emit, 8'd0);
      wait_done();
      start_run("pingpong_2", 1'b1, make_read(1'b1, 32'h0004_0000, 15, word_walk),
                lane_walk, 8'd1);
      wait_done();
      start_run("pingpong_3", 1'b1, make_read(1'b1, 32'h0005_0000, 15, word_walk),
                lane_walk, 8'd0);
      wait_done();
      start_run("fetch_disabled", 1'b0, no_read, lane_walk, 8'd1);
      wait_done();

      if (checked == 64 * 5 + 18) begin
         $display("Simulation passed");
         $finish;
      end else begin
         stop_with_failure($sformatf("only %0d output words were checked", checked));
      end
   end

endmodule

`default_nettype wire

//--- bench/vread_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module vread_mem_model import vread_cfg_pkg::*, vread_bus_pkg::*; (
   input  wire          clk,
   input  wire          rst,
   input  wire db_req_t req_i,
   output db_rsp_t      rsp_o,
   output logic [31:0]  beats_o,
   output logic         burst_done_o
);

   integer         seed = 32'hd6e2_6cd3;
   logic [LEN_W:0] idx_q;
   logic [LEN_W:0] idx;
   logic [31:0]    beats_q;
   logic           done_q;

   // a request after a finished burst starts again at beat zero
   assign idx = done_q ? '0 : idx_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         idx_q   <= '0;
         beats_q <= '0;
         done_q  <= 1'b1;
      end else if (req_i.valid && rsp_o.ready) begin
         idx_q   <= idx + 1'b1;
         beats_q <= beats_q + 32'd1;
         done_q  <= rsp_o.last;
      end
   end

   // roughly one idle cycle in four
   initial begin
      rsp_o = '0;
      forever begin
         @(negedge clk);
         rsp_o.ready = ($random(seed) & 3) != 0;
         rsp_o.rdata = (req_i.addr + 32'(idx) * 4) ^ 32'h5a5a_0000;
         rsp_o.last  = (idx == {1'b0, req_i.len});
      end
   end

   assign beats_o      = beats_q;
   assign burst_done_o = done_q;

endmodule

`default_nettype wire

//--- src/vread_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vread_addr_gen import vread_cfg_pkg::*; #(
   parameter int unsigned DELAY_W = 8
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   run_i,
   input  wire gen_cfg_t         cfg_i,
   input  wire [DELAY_W-1:0]     delay_i,
   input  wire                   ready_i,
   output logic                  valid_o,
   output logic [GEN_ADDR_W-1:0] addr_o,
   output logic                  done_o
);

   gen_cfg_t              cfg_q;
   logic [PER_W-1:0]      step_q;
   logic [GEN_ADDR_W-1:0] period_q;
   logic [GEN_ADDR_W-1:0] loop_q;
   logic [DELAY_W-1:0]    dly_q;
   logic [GEN_ADDR_W-1:0] addr_q;
   logic                  done_q;
   logic                  active;
   logic                  step_en;
   logic                  last_step;
   logic                  last_period;
   logic                  last_loop;

   assign active  = !done_q && (dly_q == '0);
   assign valid_o = active && (step_q < cfg_q.duty);
   // idle steps never wait for the consumer
   assign step_en = active && (!valid_o || ready_i);

   // a zero count behaves like one
   assign last_step   = (32'(step_q) + 32'd1) >= 32'(cfg_q.per);
   assign last_period = (32'(period_q) + 32'd1) >= 32'(cfg_q.iter);
   assign last_loop   = (32'(loop_q) + 32'd1) >= 32'(cfg_q.iter2);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         step_q   <= '0;
         period_q <= '0;
         loop_q   <= '0;
         dly_q    <= '0;
         done_q   <= 1'b1;
      end else if (run_i) begin
         step_q   <= '0;
         period_q <= '0;
         loop_q   <= '0;
         dly_q    <= delay_i;
         done_q   <= 1'b0;
      end else if (dly_q != '0) begin
         dly_q <= dly_q - 1'b1;
      end else if (step_en) begin
         if (!last_step) begin
            step_q <= step_q + 1'b1;
         end else begin
            step_q <= '0;
            if (!last_period) begin
               period_q <= period_q + 1'b1;
            end else begin
               period_q <= '0;
               if (!last_loop) begin
                  loop_q <= loop_q + 1'b1;
               end else begin
                  done_q <= 1'b1;
               end
            end
         end
      end
   end

   // settings are sampled once per run
   always_ff @(posedge clk) begin
      if (run_i) begin
         cfg_q  <= cfg_i;
         addr_q <= cfg_i.start;
      end else if (step_en) begin
         if (!last_step) begin
            addr_q <= addr_q + cfg_q.incr;
         end else if (!last_period) begin
            addr_q <= addr_q + cfg_q.shift;
         end else begin
            addr_q <= addr_q + cfg_q.shift2;
         end
      end
   end

   assign addr_o = addr_q;
   assign done_o = done_q;

endmodule

`default_nettype wire

//--- src/vread_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vread_buffer import vread_cfg_pkg::*, vread_bus_pkg::*; (
   input  wire                   clk,
   input  wire buf_wr_t          wr_i,
   input  wire buf_rd_t          rd_i,
   output logic [BUS_DATA_W-1:0] rdata_o
);

   localparam int unsigned DEPTH = 2 ** BUF_ADDR_W;

   logic [BUS_DATA_W-1:0] mem [DEPTH];
   logic [BUS_DATA_W-1:0] rdata_q;

   always_ff @(posedge clk) begin
      if (wr_i.we) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // read data shows one cycle after re
   always_ff @(posedge clk) begin
      if (rd_i.re) begin
         rdata_q <= mem[rd_i.addr];
      end
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- src/vread_bus_pkg.sv
`default_nettype none

package vread_bus_pkg;

   import vread_cfg_pkg::*;

   localparam int unsigned BUS_DATA_W = 32;

   // addr and len hold for the whole burst
   typedef struct packed {
      logic                  valid;
      logic [EXT_ADDR_W-1:0] addr;
      logic [LEN_W-1:0]      len;
   } db_req_t;

   // ready doubles as the data strobe
   typedef struct packed {
      logic                  ready;
      logic [BUS_DATA_W-1:0] rdata;
      logic                  last;
   } db_rsp_t;

   typedef struct packed {
      logic                  we;
      logic [BUF_ADDR_W-1:0] addr;
      logic [BUS_DATA_W-1:0] data;
   } buf_wr_t;

   typedef struct packed {
      logic                  re;
      logic [BUF_ADDR_W-1:0] addr;
   } buf_rd_t;

endpackage

`default_nettype wire

//--- src/vread_cfg_pkg.sv
`default_nettype none

package vread_cfg_pkg;

   // buffer words with the ping-pong bank in the top bit
   localparam int unsigned BUF_ADDR_W = 10;
   localparam int unsigned PER_W      = 8;
   localparam int unsigned EXT_ADDR_W = 32;
   // beats minus one
   localparam int unsigned LEN_W      = 8;

   // generator counts lanes with up to four lanes per word
   localparam int unsigned GEN_ADDR_W = BUF_ADDR_W + 2;

   typedef struct packed {
      logic [GEN_ADDR_W-1:0] start;
      logic [PER_W-1:0]      per;
      logic [PER_W-1:0]      duty;
      logic [GEN_ADDR_W-1:0] incr;
      logic [GEN_ADDR_W-1:0] iter;
      logic [GEN_ADDR_W-1:0] shift;
      logic [GEN_ADDR_W-1:0] iter2;
      logic [GEN_ADDR_W-1:0] shift2;
   } gen_cfg_t;

   // generator addresses on the fetch side are buffer words
   typedef struct packed {
      logic                  enabled;
      logic [EXT_ADDR_W-1:0] ext_addr;
      logic [LEN_W-1:0]      length;
      gen_cfg_t              gen;
   } read_cfg_t;

   // generator addresses on the emit side are lanes
   typedef struct packed {
      gen_cfg_t gen;
   } out_cfg_t;

endpackage

`default_nettype wire

//--- src/vread_emit.sv
`timescale 1ns/1ps
`default_nettype none

module vread_emit import vread_cfg_pkg::*, vread_bus_pkg::*; #(
   parameter int unsigned DATA_W  = 8,
   parameter int unsigned DELAY_W = 8
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   run_i,
   input  wire                   pingpong_i,
   input  wire                   bank_i,
   input  wire out_cfg_t         cfg_i,
   input  wire [DELAY_W-1:0]     delay_i,
   output buf_rd_t               buf_rd_o,
   input  wire [BUS_DATA_W-1:0]  rdata_i,
   output logic [DATA_W-1:0]     data_o,
   output logic                  data_valid_o,
   output logic                  done_o
);

   localparam int unsigned LANES     = BUS_DATA_W / DATA_W;
   localparam int unsigned LANE_BITS = $clog2(LANES);
   localparam int unsigned SEL_W     = (LANE_BITS > 0) ? LANE_BITS : 1;

   logic                  gen_valid;
   logic [GEN_ADDR_W-1:0] gen_addr;
   logic                  gen_done;
   logic [GEN_ADDR_W-1:0] word_addr;
   logic [SEL_W-1:0]      sel_d;
   logic [SEL_W-1:0]      sel_q;
   logic                  valid_q;
   logic                  done_q;

   vread_addr_gen #(
      .DELAY_W(DELAY_W)
   ) out_gen_i (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .cfg_i  (cfg_i.gen),
      .delay_i(delay_i),
      .ready_i(1'b1),
      .valid_o(gen_valid),
      .addr_o (gen_addr),
      .done_o (gen_done)
   );

   // low bits pick the lane with the lsb lane first
   assign word_addr = gen_addr >> LANE_BITS;
   assign sel_d     = (LANE_BITS == 0) ? '0 : gen_addr[SEL_W-1:0];

   always_comb begin
      buf_rd_o.re   = gen_valid;
      buf_rd_o.addr = word_addr[BUF_ADDR_W-1:0];
      if (pingpong_i) begin
         buf_rd_o.addr[BUF_ADDR_W-1] = bank_i;
      end
   end

   always_ff @(posedge clk) begin
      sel_q <= sel_d;
   end

   // done trails the generator so the last word is already out
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= 1'b0;
         done_q  <= 1'b1;
      end else begin
         valid_q <= gen_valid;
         done_q  <= run_i ? 1'b0 : gen_done;
      end
   end

   assign data_o       = rdata_i[sel_q*DATA_W +: DATA_W];
   assign data_valid_o = valid_q;
   assign done_o       = done_q;

endmodule

`default_nettype wire

//--- src/vread_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module vread_fetch import vread_cfg_pkg::*, vread_bus_pkg::*; (
   input  wire            clk,
   input  wire            rst,
   input  wire            run_i,
   input  wire            pingpong_i,
   input  wire read_cfg_t cfg_i,
   output db_req_t        db_req_o,
   input  wire db_rsp_t   db_rsp_i,
   output buf_wr_t        buf_wr_o,
   output logic           bank_o,
   output logic           done_o
);

   gen_cfg_t              gen_cfg;
   logic                  gen_valid;
   logic                  gen_ready;
   logic [GEN_ADDR_W-1:0] gen_addr;
   logic                  accept;
   logic [EXT_ADDR_W-1:0] ext_addr_q;
   logic [LEN_W-1:0]      len_q;
   logic                  bank_q;
   logic                  read_done_q;

   // single-level walk from word zero
   always_comb begin
      gen_cfg        = cfg_i.gen;
      gen_cfg.start  = '0;
      gen_cfg.iter2  = GEN_ADDR_W'(1);
      gen_cfg.shift2 = '0;
   end

   vread_addr_gen #(
      .DELAY_W(1)
   ) read_gen_i (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i && cfg_i.enabled),
      .cfg_i  (gen_cfg),
      .delay_i(1'b0),
      .ready_i(gen_ready),
      .valid_o(gen_valid),
      .addr_o (gen_addr),
      .done_o ()
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q      <= 1'b0;
         read_done_q <= 1'b1;
      end else if (run_i) begin
         bank_q      <= pingpong_i ? !bank_q : 1'b0;
         read_done_q <= !cfg_i.enabled;
      end else if (accept && db_rsp_i.last) begin
         read_done_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (run_i) begin
         ext_addr_q <= cfg_i.ext_addr;
         len_q      <= cfg_i.length;
      end
   end

   // no address ready means no request, which stalls the bus
   assign gen_ready = db_rsp_i.ready && !read_done_q;
   assign accept    = db_req_o.valid && db_rsp_i.ready;

   always_comb begin
      db_req_o.valid = gen_valid && !read_done_q;
      db_req_o.addr  = ext_addr_q;
      db_req_o.len   = len_q;
   end

   // fetch fills the bank that emit is not reading
   always_comb begin
      buf_wr_o.we   = accept;
      buf_wr_o.addr = gen_addr[BUF_ADDR_W-1:0];
      buf_wr_o.data = db_rsp_i.rdata;
      if (pingpong_i) begin
         buf_wr_o.addr[BUF_ADDR_W-1] = !bank_q;
      end
   end

   assign bank_o = bank_q;
   assign done_o = read_done_q;

endmodule

`default_nettype wire

//--- src/vread_top.sv
`timescale 1ns/1ps
`default_nettype none

module vread_top import vread_cfg_pkg::*, vread_bus_pkg::*; #(
   parameter int unsigned DATA_W  = 8,
   parameter int unsigned DELAY_W = 8
) (
   input  wire               clk,
   input  wire               rst,
   input  wire               run_i,
   input  wire               pingpong_i,
   input  wire read_cfg_t    read_cfg_i,
   input  wire out_cfg_t     out_cfg_i,
   input  wire [DELAY_W-1:0] delay_i,
   output db_req_t           db_req_o,
   input  wire db_rsp_t      db_rsp_i,
   output logic [DATA_W-1:0] data_o,
   output logic              data_valid_o,
   output logic              done_o
);

   buf_wr_t               buf_wr;
   buf_rd_t               buf_rd;
   logic [BUS_DATA_W-1:0] buf_rdata;
   logic                  bank;
   logic                  fetch_done;
   logic                  emit_done;

   vread_fetch fetch_i (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .pingpong_i(pingpong_i),
      .cfg_i     (read_cfg_i),
      .db_req_o  (db_req_o),
      .db_rsp_i  (db_rsp_i),
      .buf_wr_o  (buf_wr),
      .bank_o    (bank),
      .done_o    (fetch_done)
   );

   vread_buffer buffer_i (
      .clk    (clk),
      .wr_i   (buf_wr),
      .rd_i   (buf_rd),
      .rdata_o(buf_rdata)
   );

   vread_emit #(
      .DATA_W (DATA_W),
      .DELAY_W(DELAY_W)
   ) emit_i (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .pingpong_i  (pingpong_i),
      .bank_i      (bank),
      .cfg_i       (out_cfg_i),
      .delay_i     (delay_i),
      .buf_rd_o    (buf_rd),
      .rdata_i     (buf_rdata),
      .data_o      (data_o),
      .data_valid_o(data_valid_o),
      .done_o      (emit_done)
   );

   // either stage may finish first
   assign done_o = fetch_done && emit_done;

endmodule

`default_nettype wire

//--- vread.f
src/vread_cfg_pkg.sv
src/vread_bus_pkg.sv
src/vread_addr_gen.sv
src/vread_fetch.sv
src/vread_buffer.sv
src/vread_emit.sv
src/vread_top.sv
bench/vread_mem_model.sv
bench/tb_vread.sv
